//--- mipsParams.svh
/*
 * Single-cycle MIPS core parameters.
 * Datapath width, register file size, data memory depth and the jal link register.
 */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// ======================================================================
// datapath
// ======================================================================

// data and instruction word width
`define MIPS_XLEN 32

// ======================================================================
// register file
// ======================================================================

// architectural registers, r0 reads as zero
`define MIPS_NREGS 32
// register index width, follows the register count
`define MIPS_RADDR_W $clog2(`MIPS_NREGS)
// jal writes its return address here
`define MIPS_LINK_REG 31

// ======================================================================
// data memory
// ======================================================================

// word address width, 128 words
`define MIPS_DADDR_W 7

`endif

//--- mipsPkg.sv
/*
 * Shared types of the single-cycle MIPS core.
 * Opcode, function and ALU encodings plus the control, memory and write-back structs.
 */
`default_nettype none

`include "mipsParams.svh"

package mipsPkg;

  // ======================================================================
  // encodings
  // ======================================================================

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // R-type function field, instr[5:0]
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_AND  = 4'b0000,
    ALU_OR   = 4'b0001,
    ALU_ADD  = 4'b0010,
    ALU_SUB  = 4'b0110,
    ALU_SLT  = 4'b0111,
    ALU_NONE = 4'b1111
  } aluOp_e;

  // ======================================================================
  // bundles
  // ======================================================================

  // decoded control flags, one instruction
  typedef struct packed {
    logic regDst;    // destination is rd, else rt
    logic aluSrc;    // ALU operand b is the immediate
    logic memToReg;  // write-back from data memory
    logic memRead;   // load, data memory result is consumed
    logic regWrite;
    logic memWrite;
    logic branch;    // beq
    logic jump;      // j or jal
    logic link;      // jal
  } ctrl_t;

  // data memory request, single write enable
  typedef struct packed {
    logic                     wrEn;
    logic [`MIPS_DADDR_W-1:0] addr;
    logic [`MIPS_XLEN-1:0]    wdata;
  } memReq_t;

  // register file write port
  typedef struct packed {
    logic                     en;
    logic [`MIPS_RADDR_W-1:0] addr;
    logic [`MIPS_XLEN-1:0]    data;
  } regWb_t;

endpackage

`default_nettype wire

//--- controlUnit.sv
/*
 * Main and ALU-function decode of the MIPS core.
 * Turns opcode and function field into control flags and an ALU operation.
 */
`default_nettype none

module controlUnit import mipsPkg::*; (
  input  opcode_e opcode,
  input  funct_e  funct,
  output ctrl_t   ctrl,
  output aluOp_e  aluOp
);

  // ======================================================================
  // decode
  // ======================================================================

  always_comb begin
    // default is a bubble: no writes, no flow change
    ctrl  = '0;
    aluOp = ALU_NONE;

    case (opcode)
      OP_RTYPE: begin
        // only the supported functions write rd
        case (funct)
          FN_ADD: aluOp = ALU_ADD;
          FN_SUB: aluOp = ALU_SUB;
          FN_AND: aluOp = ALU_AND;
          FN_OR:  aluOp = ALU_OR;
          FN_SLT: aluOp = ALU_SLT;
          default: aluOp = ALU_NONE;
        endcase
        ctrl.regDst   = (aluOp != ALU_NONE);
        ctrl.regWrite = (aluOp != ALU_NONE);
      end
      OP_LW: begin
        // base plus offset, result from memory into rt
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.regWrite = 1'b1;
        aluOp         = ALU_ADD;
      end
      OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        aluOp         = ALU_ADD;
      end
      OP_BEQ: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        aluOp       = ALU_SUB;
      end
      OP_J: begin
        ctrl.jump = 1'b1;
      end
      OP_JAL: begin
        // return address goes to the link register
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
        // unknown opcode, keep the bubble
        ctrl  = '0;
        aluOp = ALU_NONE;
      end
    endcase
  end

  // ======================================================================
  // checks
  // ======================================================================

  // no entry of the decode table both stores and writes back
  always_comb begin
    assert (!(ctrl.memWrite && ctrl.regWrite))
      else $error("controlUnit: store and register write set together");
  end

endmodule

`default_nettype wire

//--- alu.sv
/*
 * 32-bit ALU of the MIPS core.
 * and, or, add, sub and signed set-less-than, with a zero flag for beq.
 */
`default_nettype none

`include "mipsParams.svh"

module alu import mipsPkg::*; (
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] b,
  input  aluOp_e                op,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);

  // signed compare for slt
  logic aLessB;

  assign aLessB = ($signed(a) < $signed(b));

  // ======================================================================
  // operation select
  // ======================================================================

  always_comb begin
    case (op)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      // single result bit, rest cleared
      ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, aLessB};
      // none and anything unknown give zero
      default: result = '0;
    endcase
  end

  // flag on any zero result, branch logic only reads it for beq
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- regFile.sv
/*
 * MIPS register file, 32 x 32.
 * Two combinational read ports, one write port on the clock edge, r0 fixed at zero.
 */
`default_nettype none

`include "mipsParams.svh"

module regFile import mipsPkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`MIPS_RADDR_W-1:0] rdAddr1,
  input  logic [`MIPS_RADDR_W-1:0] rdAddr2,
  input  regWb_t                   wr,
  output logic [`MIPS_XLEN-1:0]    rdData1,
  output logic [`MIPS_XLEN-1:0]    rdData2
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

  // ======================================================================
  // write port
  // ======================================================================

  // whole file cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en && (wr.addr != '0)) begin
      // writes to r0 are dropped
      regs[wr.addr] <= wr.data;
    end
  end

  // ======================================================================
  // read ports
  // ======================================================================

  assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

  // write-back data must be resolved, whatever source the top selected
  assert property (@(posedge clk) disable iff (!rst) wr.en |-> !$isunknown(wr.data))
    else $error("regFile: unknown write data to r%0d", wr.addr);

endmodule

`default_nettype wire

//--- pcUnit.sv
/*
 * Program counter of the MIPS core.
 * Holds the PC and picks jump, taken branch or PC + 4 as the next address.
 */
`default_nettype none

`include "mipsParams.svh"

module pcUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  branch,
  input  logic                  jump,
  input  logic                  zero,
  input  logic [`MIPS_XLEN-1:0] imm,
  input  logic [25:0]           target,
  output logic [`MIPS_XLEN-1:0] pc,
  output logic [`MIPS_XLEN-1:0] pcPlus8
);

  logic [`MIPS_XLEN-1:0] pcPlus4;
  logic [`MIPS_XLEN-1:0] pcNext;

  assign pcPlus4 = pc + `MIPS_XLEN'(4);
  // jal return address, skips the delay slot
  assign pcPlus8 = pc + `MIPS_XLEN'(8);

  // jump first, then taken beq, else fall through
  always_comb begin
    if (jump) begin
      pcNext = {pcPlus4[`MIPS_XLEN-1:`MIPS_XLEN-4], target, 2'b00};
    end else if (branch && zero) begin
      pcNext = pcPlus4 + {imm[`MIPS_XLEN-3:0], 2'b00};
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

  // word fetches only, across every jump and branch taken
  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pcUnit: misaligned pc %h", pc);

endmodule

`default_nettype wire

//--- singleCycleMips.sv
/*
 * Single-cycle MIPS core, top level.
 * Fetch, decode, execute, memory and write-back in one clock, memories outside.
 */
`default_nettype none

`include "mipsParams.svh"

module singleCycleMips import mipsPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MIPS_XLEN-1:0] instr,
  input  logic [`MIPS_XLEN-1:0] memRdata,
  output logic [`MIPS_XLEN-1:0] instrAddr,
  output memReq_t               memReq,
  output regWb_t                wb
);

  // ======================================================================
  // instruction fields
  // ======================================================================

  opcode_e                  opcode;
  funct_e                   funct;
  logic [`MIPS_RADDR_W-1:0] rs;
  logic [`MIPS_RADDR_W-1:0] rt;
  logic [`MIPS_RADDR_W-1:0] rd;
  logic [`MIPS_RADDR_W-1:0] wbAddr;
  logic [`MIPS_XLEN-1:0]    immExt;
  logic [`MIPS_XLEN-1:0]    rdData1;
  logic [`MIPS_XLEN-1:0]    rdData2;
  logic [`MIPS_XLEN-1:0]    aluB;
  logic [`MIPS_XLEN-1:0]    aluResult;
  logic [`MIPS_XLEN-1:0]    wbData;
  logic [`MIPS_XLEN-1:0]    pc;
  logic [`MIPS_XLEN-1:0]    pcPlus8;
  logic                     aluZero;
  ctrl_t                    ctrl;
  aluOp_e                   aluOp;

  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  // 16-bit offset, sign extended
  assign immExt = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};

  // ======================================================================
  // blocks
  // ======================================================================

  controlUnit uCtrl (.opcode(opcode), .funct(funct), .ctrl(ctrl), .aluOp(aluOp));

  regFile uRegs (
    .clk(clk), .rst(rst), .rdAddr1(rs), .rdAddr2(rt), .wr(wb),
    .rdData1(rdData1), .rdData2(rdData2)
  );

  // register or immediate for operand b
  assign aluB = ctrl.aluSrc ? immExt : rdData2;

  alu uAlu (.a(rdData1), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero));

  pcUnit uPc (
    .clk(clk), .rst(rst), .branch(ctrl.branch), .jump(ctrl.jump), .zero(aluZero),
    .imm(immExt), .target(instr[25:0]), .pc(pc), .pcPlus8(pcPlus8)
  );

  // ======================================================================
  // memory and write-back
  // ======================================================================

  assign instrAddr = pc;
  // byte address from the ALU, word index to the memory
  assign memReq = '{wrEn: ctrl.memWrite, addr: aluResult[`MIPS_DADDR_W+1:2], wdata: rdData2};

  // jal targets the link register, R-type rd, the rest rt
  assign wbAddr = ctrl.link   ? `MIPS_RADDR_W'(`MIPS_LINK_REG) :
                  ctrl.regDst ? rd : rt;
  assign wbData = ctrl.link     ? pcPlus8  :
                  ctrl.memToReg ? memRdata : aluResult;
  assign wb = '{en: ctrl.regWrite, addr: wbAddr, data: wbData};

  // a load must present a resolved word address to the data memory
  assert property (@(posedge clk) disable iff (!rst) ctrl.memRead |-> !$isunknown(memReq.addr))
    else $error("singleCycleMips: load with unknown address at pc %h", pc);

endmodule

`default_nettype wire

//--- tbChecker.sv
/*
 * Result checker of the MIPS testbench.
 * Compares write-back, store and next address with the current table entry.
 */
`default_nettype none

`include "mipsParams.svh"

module tbChecker import mipsPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`MIPS_XLEN-1:0] instrAddr,
  input  memReq_t               memReq,
  input  regWb_t                wb,
  input  logic                  expValid,
  input  logic [8*16-1:0]       expName,
  input  regWb_t                expWb,
  input  memReq_t               expMem,
  input  logic [`MIPS_XLEN-1:0] expNext,
  output logic                  done,
  output int                    passCount,
  output int                    failCount
);

  logic                  finished = 1'b0;
  int                    nPass = 0;
  int                    nFail = 0;
  // the test in flight, closed once its next address shows up
  logic                  pending = 1'b0;
  logic [8*16-1:0]       pendName = '0;
  int                    pendErrs = 0;
  logic                  pendFinal = 1'b0;
  logic [`MIPS_XLEN-1:0] expPc = '0;

  assign done      = finished;
  assign passCount = nPass;
  assign failCount = nFail;

  // packed name to text, leading nul bytes dropped
  function automatic string nameText(logic [8*16-1:0] v);
    string s;
    s = "";
    for (int i = 15; i >= 0; i--) begin
      if (v[i*8 +: 8] != 8'h00) begin
        s = $sformatf("%s%c", s, v[i*8 +: 8]);
      end
    end
    return s;
  endfunction

  function automatic int compareField(string test, string field, logic [31:0] expected,
                                      logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %0s %0s: expected %h, actual %h", test, field, expected, actual);
      return 1;
    end
    return 0;
  endfunction

  // ======================================================================
  // compare at the rising edge, outputs settled since the falling edge
  // ======================================================================

  always @(posedge clk) begin : compare
    int errs;
    errs = 0;
    if (rst && !finished) begin
      if (pending) begin
        pendErrs = pendErrs + compareField(nameText(pendName), "next address", expPc, instrAddr);
        if (pendErrs == 0) begin
          $display("test %0s: ok", nameText(pendName));
          nPass++;
        end else begin
          $display("test %0s: failed with %0d errors", nameText(pendName), pendErrs);
          nFail++;
        end
        finished = pendFinal;
      end else if (instrAddr !== '0) begin
        $display("first fetch after reset went to %h instead of address 0", instrAddr);
        nFail++;
      end
      if (!finished && !expValid) begin
        $display("fetch from %h lies outside the program", instrAddr);
        nFail++;
        finished = 1'b1;
      end else if (!finished) begin
        errs += compareField(nameText(expName), "wb.en", 32'(expWb.en), 32'(wb.en));
        if (expWb.en) begin
          errs += compareField(nameText(expName), "wb.addr", 32'(expWb.addr), 32'(wb.addr));
          errs += compareField(nameText(expName), "wb.data", expWb.data, wb.data);
        end
        errs += compareField(nameText(expName), "memReq.wrEn", 32'(expMem.wrEn),
                             32'(memReq.wrEn));
        if (expMem.wrEn) begin
          errs += compareField(nameText(expName), "memReq.addr", 32'(expMem.addr),
                               32'(memReq.addr));
          errs += compareField(nameText(expName), "memReq.wdata", expMem.wdata, memReq.wdata);
        end
        // self-jump marks the end of the program
        pending   = 1'b1;
        pendName  = expName;
        pendErrs  = errs;
        pendFinal = (expNext == instrAddr);
        expPc     = expNext;
      end
    end
  end

endmodule

`default_nettype wire

//--- tbMips.sv
/*
 * Testbench of the single-cycle MIPS core.
 * Runs a table-driven program, models instruction and data memory.
 */
`default_nettype none

`include "mipsParams.svh"

module tbMips import mipsPkg::*; ();

  localparam int NTESTS = 25;
  localparam int PERIOD = 4;
  // four cycles per entry, plus the reset
  localparam int TIMEOUT = (NTESTS * 4 + 5) * PERIOD;

  // one program word and what it must do
  typedef struct packed {
    logic [8*16-1:0]       name;
    logic [`MIPS_XLEN-1:0] instr;
    regWb_t                wb;
    memReq_t               mem;
    logic [`MIPS_XLEN-1:0] next;
  } test_t;

  logic                  clk = 1'b0;
  logic                  rst = 1'b0;
  logic [`MIPS_XLEN-1:0] instr = '0;
  logic [`MIPS_XLEN-1:0] memRdata;
  logic [`MIPS_XLEN-1:0] instrAddr;
  memReq_t               memReq;
  regWb_t                wb;
  test_t                 tests [NTESTS];
  test_t                 cur = '0;
  logic                  curValid = 1'b0;
  logic [`MIPS_XLEN-1:0] dmem [2**`MIPS_DADDR_W];
  logic                  done;
  int                    passCount;
  int                    failCount;
  int                    nAdded = 0;

  singleCycleMips uut (.clk(clk), .rst(rst), .instr(instr), .memRdata(memRdata),
                       .instrAddr(instrAddr), .memReq(memReq), .wb(wb));

  tbChecker uChk (.clk(clk), .rst(rst), .instrAddr(instrAddr), .memReq(memReq), .wb(wb),
                  .expValid(curValid), .expName(cur.name), .expWb(cur.wb), .expMem(cur.mem),
                  .expNext(cur.next), .done(done), .passCount(passCount),
                  .failCount(failCount));

  // ======================================================================
  // instruction encoding
  // ======================================================================

  function automatic logic [31:0] rType(int rs, int rt, int rd, funct_e fn);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(opcode_e op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic logic [31:0] jType(opcode_e op, int target);
    return {op, 26'(target)};
  endfunction

  // data memory fill, word index in the top and bottom bits
  function automatic logic [31:0] memInit(int i);
    return {7'(i), 18'd0, 7'(i)};
  endfunction

  task automatic addTest(input logic [8*16-1:0] name, input logic [31:0] word,
                         input int wbEn, input int wbAddr, input logic [31:0] wbData,
                         input int stEn, input int stAddr, input logic [31:0] stData,
                         input int next);
    tests[5'(nAdded)] = '{name: name, instr: word,
                          wb: '{1'(wbEn), 5'(wbAddr), wbData},
                          mem: '{1'(stEn), 7'(stAddr), stData},
                          next: 32'(next)};
    nAdded++;
  endtask

  // address the program jumps over
  task automatic skipEntry();
    addTest("not reached", 32'hFC00_0000, 0, 0, 0, 0, 0, 0, 4 * nAdded + 4);
  endtask

  // ======================================================================
  // program, one entry per word address
  // ======================================================================

  task automatic buildProgram();
    addTest("add r1,r0,r0", rType(0, 0, 1, FN_ADD), 1, 1, 32'h0, 0, 0, 0, 4);
    addTest("lw r2,4(r0)", iType(OP_LW, 0, 2, 4), 1, 2, 32'h0200_0001, 0, 0, 0, 8);
    addTest("lw r3,8(r0)", iType(OP_LW, 0, 3, 8), 1, 3, 32'h0400_0002, 0, 0, 0, 12);
    addTest("lw r4,400(r0)", iType(OP_LW, 0, 4, 400), 1, 4, 32'hC800_0064, 0, 0, 0, 16);
    addTest("add r5,r2,r3", rType(2, 3, 5, FN_ADD), 1, 5, 32'h0600_0003, 0, 0, 0, 20);
    addTest("sub r6,r3,r2", rType(3, 2, 6, FN_SUB), 1, 6, 32'h0200_0001, 0, 0, 0, 24);
    addTest("and r7,r5,r3", rType(5, 3, 7, FN_AND), 1, 7, 32'h0400_0002, 0, 0, 0, 28);
    addTest("or r8,r2,r4", rType(2, 4, 8, FN_OR), 1, 8, 32'hCA00_0065, 0, 0, 0, 32);
    // negative r4 against positive r2
    addTest("slt r9,r4,r2", rType(4, 2, 9, FN_SLT), 1, 9, 32'h1, 0, 0, 0, 36);
    addTest("slt r10,r2,r4", rType(2, 4, 10, FN_SLT), 1, 10, 32'h0, 0, 0, 0, 40);
    addTest("sw r5,40(r0)", iType(OP_SW, 0, 5, 40), 0, 0, 0, 1, 10, 32'h0600_0003, 44);
    addTest("lw r11,40(r0)", iType(OP_LW, 0, 11, 40), 1, 11, 32'h0600_0003, 0, 0, 0, 48);
    // 52 + 2 * 4
    addTest("beq taken", iType(OP_BEQ, 5, 11, 2), 0, 0, 0, 0, 0, 0, 60);
    skipEntry();
    skipEntry();
    addTest("beq not taken", iType(OP_BEQ, 2, 3, 5), 0, 0, 0, 0, 0, 0, 64);
    addTest("j forward", jType(OP_J, 18), 0, 0, 0, 0, 0, 0, 72);
    skipEntry();
    // return address is pc + 8
    addTest("jal r31", jType(OP_JAL, 21), 1, 31, 32'd80, 0, 0, 0, 84);
    skipEntry();
    skipEntry();
    addTest("add r0 dropped", rType(2, 3, 0, FN_ADD), 1, 0, 32'h0600_0003, 0, 0, 0, 88);
    addTest("r0 reads zero", rType(0, 2, 12, FN_ADD), 1, 12, 32'h0200_0001, 0, 0, 0, 92);
    addTest("unknown opcode", 32'hFC00_0000, 0, 0, 0, 0, 0, 0, 96);
    addTest("final self jump", jType(OP_J, 24), 0, 0, 0, 0, 0, 0, 96);
  endtask

  // ======================================================================
  // clock, memories, run control
  // ======================================================================

  initial begin
    forever #(PERIOD / 2) clk = ~clk;
  end

  // instruction fetch on the falling edge
  always @(negedge clk) begin : fetch
    int idx;
    idx = int'(instrAddr >> 2);
    curValid = (instrAddr[1:0] == 2'b00) && (idx < NTESTS);
    cur      = curValid ? tests[5'(idx)] : '0;
    instr    = cur.instr;
  end

  assign memRdata = dmem[memReq.addr];

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 2**`MIPS_DADDR_W; i++) begin
        dmem[7'(i)] <= memInit(i);
      end
    end else if (memReq.wrEn) begin
      dmem[memReq.addr] <= memReq.wdata;
    end
  end

  initial begin
    buildProgram();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    wait (done);
    $display("%0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT);
    $display("timeout: program never reached its final self-jump in %0d time units", TIMEOUT);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
mipsPkg.sv
controlUnit.sv
alu.sv
regFile.sv
pcUnit.sv
singleCycleMips.sv
tbChecker.sv
tbMips.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbMips
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

SOURCES = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
